// ==== hdl/music_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, song table rule and tone constants
// Referenced by scoped name from every block of the music player
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package music_pkg;

    // Note number, zero is a rest
    typedef logic [5:0] note_t;
    // Note length in beats
    typedef logic [5:0] duration_t;
    typedef logic [1:0] song_t;
    // Signed codec sample
    typedef logic signed [17:0] sample_t;
    typedef logic [15:0] phase_t;
    // Volume weight, amplitude shift
    typedef logic [1:0] weight_t;

    localparam int NOTES_PER_SONG = 8;
    // Phase step per note number
    localparam int STEP_SCALE = 64;
    // Square wave amplitude at weight 0
    localparam int BASE_AMPLITUDE = 4096;

    // Control FSM states
    typedef enum logic [1:0] {
        paused,
        playing,
        next_wait
    } mcu_state_t;

    // Note number of entry i in song s
    function automatic note_t song_entry_note(
        input song_t s,
        input logic [$clog2(NOTES_PER_SONG)-1:0] i
    );
        return note_t'(int'(s) * NOTES_PER_SONG + int'(i) + 1);
    endfunction

    // Duration of entry i, cycles through 1 to 4 beats
    function automatic duration_t song_entry_duration(
        input logic [$clog2(NOTES_PER_SONG)-1:0] i
    );
        return duration_t'(int'(i) % 4 + 1);
    endfunction

endpackage

// ==== hdl/mcu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Master control FSM for play/pause and song selection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mcu (
    input  logic              clk,
    input  logic              rst,
    input  logic              play_button,
    input  logic              next_button,
    input  logic              song_done,
    output logic              play,
    output logic              reset_player,
    output music_pkg::song_t  song
);

    music_pkg::mcu_state_t state;
    music_pkg::mcu_state_t state_next;
    logic advance;

    // Skip request from the user, or end of song from the reader
    assign advance = (next_button || song_done) && (state != music_pkg::next_wait);

    always_comb begin
        state_next = state;
        case (state)
            music_pkg::paused: begin
                if (advance)
                    state_next = music_pkg::next_wait;
                else if (play_button)
                    state_next = music_pkg::playing;
            end
            music_pkg::playing: begin
                if (advance)
                    state_next = music_pkg::next_wait;
                else if (play_button)
                    state_next = music_pkg::paused;
            end
            // Reader is being cleared this cycle, wait for a new play press
            music_pkg::next_wait: state_next = music_pkg::paused;
            default: state_next = music_pkg::paused;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= music_pkg::paused;
            song         <= '0;
            play         <= 1'b0;
            reset_player <= 1'b0;
        end else begin
            state        <= state_next;
            play         <= (state_next == music_pkg::playing);
            // One pulse, lands in the next_wait cycle
            reset_player <= advance;
            if (advance)
                song <= song + 1'b1;
        end
    end

    // Song reader is never cleared while the player is running
    assert property (@(posedge clk) disable iff (rst) !(reset_player && play))
        else $error("reset_player high while play is high");

endmodule

// ==== hdl/song_reader.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage, walks the song table and issues notes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module song_reader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  play,
    input  logic                  ff_switch,
    input  logic                  note_done,
    input  music_pkg::song_t      song,
    output music_pkg::note_t      note,
    output music_pkg::duration_t  duration,
    output logic                  new_note,
    output logic                  activate,
    output logic                  song_done
);

    localparam int IDX_W = $clog2(music_pkg::NOTES_PER_SONG);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(music_pkg::NOTES_PER_SONG - 1);

    logic [IDX_W-1:0] index;
    logic read_pending;
    logic song_over;
    logic start;
    logic last_note;
    music_pkg::duration_t table_dur;
    music_pkg::duration_t ff_dur;

    // First play press after reset or song change
    assign start     = play && !activate && !song_over;
    assign last_note = (index == LAST_IDX);

    // Table lookup for the current entry
    assign table_dur = music_pkg::song_entry_duration(index);
    // Fast forward halves, never below one beat
    assign ff_dur    = (table_dur > 6'd1) ? (table_dur >> 1) : 6'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            index        <= '0;
            activate     <= 1'b0;
            song_over    <= 1'b0;
            read_pending <= 1'b0;
            new_note     <= 1'b0;
            song_done    <= 1'b0;
        end else begin
            read_pending <= 1'b0;
            song_done    <= 1'b0;
            // Note registers are loaded one cycle before the strobe
            new_note     <= read_pending;
            if (start) begin
                activate     <= 1'b1;
                read_pending <= 1'b1;
            end else if (activate && note_done) begin
                if (last_note) begin
                    // Stay idle until the MCU clears us
                    activate  <= 1'b0;
                    song_over <= 1'b1;
                    song_done <= 1'b1;
                end else begin
                    index        <= index + 1'b1;
                    read_pending <= 1'b1;
                end
            end
        end
    end

    // Registered table read
    always_ff @(posedge clk) begin
        if (read_pending) begin
            note     <= music_pkg::song_entry_note(song, index);
            duration <= ff_switch ? ff_dur : table_dur;
        end
    end

    // Note player ends a note before the next one is issued
    assert property (@(posedge clk) disable iff (rst) !(new_note && note_done))
        else $error("new_note and note_done high together");

endmodule

// ==== hdl/note_player.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage, square wave voice with beat counted notes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module note_player (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  play,
    input  logic                  new_note,
    input  logic                  activate,
    input  logic                  beat,
    input  logic                  generate_next_sample,
    input  music_pkg::note_t      note,
    input  music_pkg::duration_t  duration,
    input  music_pkg::weight_t    weight,
    output music_pkg::sample_t    sample,
    output logic                  note_done,
    output logic                  sample_ready
);

    music_pkg::note_t     note_reg;
    music_pkg::duration_t dur_reg;
    music_pkg::duration_t beat_cnt;
    music_pkg::phase_t    phase;
    music_pkg::phase_t    phase_next;
    music_pkg::sample_t   amplitude;
    logic busy;
    logic sounding;

    // A loaded note that is allowed to make sound
    assign sounding   = play && activate && busy;
    assign phase_next = phase + music_pkg::phase_t'(int'(note_reg) * music_pkg::STEP_SCALE);
    // Weight scales by powers of two
    assign amplitude  = music_pkg::sample_t'(music_pkg::BASE_AMPLITUDE) << weight;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            beat_cnt     <= '0;
            note_done    <= 1'b0;
            sample       <= '0;
            sample_ready <= 1'b0;
        end else begin
            note_done    <= 1'b0;
            sample_ready <= generate_next_sample;
            if (new_note) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (!activate) begin
                busy <= 1'b0;
            end else if (busy && play && beat) begin
                // Last beat of the note
                if (music_pkg::duration_t'(beat_cnt + 1'b1) == dur_reg) begin
                    note_done <= 1'b1;
                    busy      <= 1'b0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
            if (generate_next_sample) begin
                if (!sounding || note_reg == '0)
                    sample <= '0;
                else if (phase_next[$bits(music_pkg::phase_t)-1])
                    sample <= amplitude;
                else
                    sample <= -amplitude;
            end
        end
    end

    // Note payload and phase accumulator
    always_ff @(posedge clk) begin
        if (new_note) begin
            note_reg <= note;
            dur_reg  <= duration;
            phase    <= '0;
        end else if (generate_next_sample && sounding) begin
            // Phase holds while paused
            phase <= phase_next;
        end
    end

endmodule

// ==== hdl/beat_generator.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Divides sample strobes down to a one cycle beat
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module beat_generator #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic beat
);

    localparam int CNT_W = (BEAT_COUNT > 1) ? $clog2(BEAT_COUNT) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(BEAT_COUNT - 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            beat  <= 1'b0;
        end else begin
            // Pulse on the last enable of each group
            beat <= en && (count == LAST);
            if (en)
                count <= (count == LAST) ? '0 : count + 1'b1;
        end
    end

endmodule

// ==== hdl/codec_conditioner.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage, hands one sample to the codec per frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module codec_conditioner (
    input  logic                clk,
    input  logic                rst,
    input  logic                new_frame,
    input  logic                sample_ready,
    input  music_pkg::sample_t  new_sample,
    output logic                generate_next_sample,
    output music_pkg::sample_t  sample_out
);

    // Newest sample from the note player
    music_pkg::sample_t latched;

    always_ff @(posedge clk) begin
        if (rst) begin
            latched              <= '0;
            sample_out           <= '0;
            generate_next_sample <= 1'b0;
        end else begin
            // Request the next sample right after each frame
            generate_next_sample <= new_frame;
            if (sample_ready)
                latched <= new_sample;
            // Codec gets the sample made after the previous frame
            if (new_frame)
                sample_out <= latched;
        end
    end

    // Frames never arrive back to back
    assert property (@(posedge clk) disable iff (rst)
        generate_next_sample |=> !generate_next_sample)
        else $error("generate_next_sample longer than one cycle");

endmodule

// ==== hdl/music_player.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Music player top, control through codec hand-off
// Set BEAT_COUNT low in simulation for short beats
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module music_player #(
    parameter int BEAT_COUNT = 1000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                play_button,
    input  logic                next_button,
    input  logic                ff_switch,
    input  logic                new_frame,
    input  music_pkg::weight_t  weight,
    output logic                new_sample_generated,
    output logic                play,
    output music_pkg::sample_t  sample_out
);

    // Control
    logic reset_player;
    logic song_done;
    music_pkg::song_t current_song;

    // Decode to execute
    music_pkg::note_t note_to_play;
    music_pkg::duration_t duration_for_note;
    logic new_note;
    logic activate;
    logic note_done;

    // Execute to result
    logic beat;
    logic sample_ready;
    music_pkg::sample_t note_sample;

    mcu mcu_inst (
        .clk          (clk),
        .rst          (rst),
        .play_button  (play_button),
        .next_button  (next_button),
        .song_done    (song_done),
        .play         (play),
        .reset_player (reset_player),
        .song         (current_song)
    );

    // Only the reader restarts on a song change
    song_reader song_reader_inst (
        .clk       (clk),
        .rst       (rst | reset_player),
        .play      (play),
        .ff_switch (ff_switch),
        .note_done (note_done),
        .song      (current_song),
        .note      (note_to_play),
        .duration  (duration_for_note),
        .new_note  (new_note),
        .activate  (activate),
        .song_done (song_done)
    );

    note_player note_player_inst (
        .clk                  (clk),
        .rst                  (rst),
        .play                 (play),
        .new_note             (new_note),
        .activate             (activate),
        .beat                 (beat),
        .generate_next_sample (new_sample_generated),
        .note                 (note_to_play),
        .duration             (duration_for_note),
        .weight               (weight),
        .sample               (note_sample),
        .note_done            (note_done),
        .sample_ready         (sample_ready)
    );

    // One beat per BEAT_COUNT sample requests
    beat_generator #(
        .BEAT_COUNT (BEAT_COUNT)
    ) beat_generator_inst (
        .clk  (clk),
        .rst  (rst),
        .en   (new_sample_generated),
        .beat (beat)
    );

    codec_conditioner codec_conditioner_inst (
        .clk                  (clk),
        .rst                  (rst),
        .new_frame            (new_frame),
        .sample_ready         (sample_ready),
        .new_sample           (note_sample),
        .generate_next_sample (new_sample_generated),
        .sample_out           (sample_out)
    );

endmodule

// ==== bench/music_player_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Music player testbench comparing sample_out and play with a frame level model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module music_player_tb;

    localparam int BEAT_COUNT = 4;
    localparam int ACT_NONE = 0;
    localparam int ACT_PLAY = 1;
    localparam int ACT_NEXT = 2;

    logic clk;
    logic rst;
    logic play_button;
    logic next_button;
    logic ff_switch;
    logic new_frame;
    music_pkg::weight_t weight;
    logic new_sample_generated;
    logic play;
    music_pkg::sample_t sample_out;

    integer seed;
    int checks;
    int errors;
    int failures;

    // Model state advanced once per frame
    bit m_play;
    bit m_active;
    bit m_busy;
    int m_song;
    int m_index;
    int m_note;
    int m_dur;
    int m_beat_cnt;
    int m_beat_div;
    logic [15:0] m_phase;
    logic signed [17:0] m_latched;

    // Expected values with one entry per frame
    logic signed [17:0] exp_sample_q[$];
    bit exp_play_q[$];

    music_player #(
        .BEAT_COUNT (BEAT_COUNT)
    ) music_player_inst (
        .clk                  (clk),
        .rst                  (rst),
        .play_button          (play_button),
        .next_button          (next_button),
        .ff_switch            (ff_switch),
        .new_frame            (new_frame),
        .weight               (weight),
        .new_sample_generated (new_sample_generated),
        .play                 (play),
        .sample_out           (sample_out)
    );

    always #50 clk = ~clk;

    // Loads entry m_index of song m_song
    // Fast forward halves the duration down to one beat at least
    function automatic void load_note();
        int table_dur;
        table_dur = m_index % 4 + 1;
        m_note = music_pkg::NOTES_PER_SONG * m_song + m_index + 1;
        if (ff_switch)
            m_dur = (table_dur > 1) ? table_dur / 2 : 1;
        else
            m_dur = table_dur;
        m_beat_cnt = 0;
        m_phase = '0;
        m_busy = 1'b1;
    endfunction

    function automatic void press_play();
        if (m_play) begin
            m_play = 1'b0;
        end else begin
            m_play = 1'b1;
            // Fresh start only when no song is in progress
            if (!m_active) begin
                m_active = 1'b1;
                m_index = 0;
                load_note();
            end
        end
    endfunction

    function automatic void press_next();
        m_play = 1'b0;
        m_active = 1'b0;
        m_busy = 1'b0;
        m_index = 0;
        m_song = (m_song + 1) % 4;
    endfunction

    // Returns the expected sample_out for this frame and steps the model
    function automatic logic signed [17:0] step_frame();
        logic signed [17:0] shown;
        int amp;
        bit beat;
        shown = m_latched;
        if (m_play && m_active && m_busy && m_note != 0) begin
            m_phase = m_phase + 16'(m_note * music_pkg::STEP_SCALE);
            amp = music_pkg::BASE_AMPLITUDE << weight;
            m_latched = m_phase[15] ? 18'(amp) : 18'(-amp);
        end else begin
            m_latched = '0;
        end
        // Beat on every BEAT_COUNT-th frame since reset
        beat = (m_beat_div == BEAT_COUNT - 1);
        m_beat_div = (m_beat_div + 1) % BEAT_COUNT;
        if (beat && m_play && m_active && m_busy) begin
            if (m_beat_cnt + 1 == m_dur) begin
                m_busy = 1'b0;
                if (m_index == music_pkg::NOTES_PER_SONG - 1) begin
                    // MCU moves to the next song and pauses after the last entry
                    press_next();
                end else begin
                    m_index++;
                    load_note();
                end
            end else begin
                m_beat_cnt++;
            end
        end
        return shown;
    endfunction

    task automatic compare_value(input string name, input logic [17:0] expected,
                                 input logic [17:0] got);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %s expected %h got %h", name, expected, got);
        end
    endtask

    task automatic report_and_finish();
        $display("checks %0d, value errors %0d, other errors %0d", checks, errors, failures);
        if (errors == 0 && failures == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    // One 16 cycle frame with an optional button press 8 cycles in
    task automatic drive_frame(input int action);
        int waited;
        @(negedge clk);
        exp_play_q.push_back(m_play);
        exp_sample_q.push_back(step_frame());
        new_frame <= 1'b1;
        @(negedge clk);
        new_frame <= 1'b0;
        waited = 1;
        while (new_sample_generated !== 1'b1 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (new_sample_generated !== 1'b1) begin
            failures++;
            $display("timed out waiting for new_sample_generated after new_frame");
            report_and_finish();
        end
        repeat (8 - waited) @(negedge clk);
        if (action == ACT_PLAY) begin
            play_button <= 1'b1;
            press_play();
        end else if (action == ACT_NEXT) begin
            next_button <= 1'b1;
            press_next();
        end
        @(negedge clk);
        play_button <= 1'b0;
        next_button <= 1'b0;
        repeat (6) @(negedge clk);
    endtask

    task automatic idle_frames(input int n);
        repeat (n) drive_frame(ACT_NONE);
    endtask

    // Runs frames until play drops at the end of a song
    task automatic play_to_end();
        int waited;
        waited = 0;
        while (play === 1'b1 && waited < 100) begin
            drive_frame(ACT_NONE);
            waited++;
        end
        if (play === 1'b1) begin
            failures++;
            $display("timed out waiting for play to drop at the end of the song");
            report_and_finish();
        end
    endtask

    function automatic int random_gap();
        return $random(seed) & 3;
    endfunction

    // Checks the pulse position every cycle and sample_out and play on each pulse
    initial begin : compare_outputs
        logic signed [17:0] exp_sample;
        bit exp_play;
        forever begin
            @(negedge clk);
            if (rst === 1'b0) begin
                compare_value("new_sample_generated", 18'(new_frame), 18'(new_sample_generated));
                if (new_sample_generated === 1'b1) begin
                    if (exp_sample_q.size() == 0) begin
                        failures++;
                        $display("new_sample_generated pulsed with no frame pending");
                    end else begin
                        exp_sample = exp_sample_q.pop_front();
                        exp_play = exp_play_q.pop_front();
                        compare_value("sample_out", exp_sample, sample_out);
                        compare_value("play", 18'(exp_play), 18'(play));
                    end
                end
            end
        end
    end

    initial begin : stimulus
        seed = 32'h625cb699;
        checks = 0;
        errors = 0;
        failures = 0;
        clk = 1'b0;
        rst = 1'b1;
        play_button = 1'b0;
        next_button = 1'b0;
        ff_switch = 1'b0;
        new_frame = 1'b0;
        weight = 2'd1;
        m_play = 1'b0;
        m_active = 1'b0;
        m_busy = 1'b0;
        m_song = 0;
        m_index = 0;
        m_note = 0;
        m_dur = 0;
        m_beat_cnt = 0;
        m_beat_div = 0;
        m_phase = '0;
        m_latched = '0;
        repeat (10) @(negedge clk);
        rst <= 1'b0;
        @(negedge clk);
        // Quiet outputs after reset
        compare_value("play", 18'd0, 18'(play));
        compare_value("new_sample_generated", 18'd0, 18'(new_sample_generated));
        compare_value("sample_out", 18'd0, sample_out);
        // Silence and no progress while paused
        idle_frames(3 + random_gap());
        drive_frame(ACT_PLAY);
        idle_frames(20 + random_gap());
        // Pause mid note and resume where it stopped
        drive_frame(ACT_PLAY);
        idle_frames(3 + random_gap());
        drive_frame(ACT_PLAY);
        idle_frames(6);
        // Volume steps within a note
        weight <= 2'd3;
        idle_frames(5);
        weight <= 2'd0;
        idle_frames(4);
        weight <= 2'd2;
        idle_frames(4);
        // Fast forward to the end of song 0
        ff_switch <= 1'b1;
        play_to_end();
        idle_frames(2 + random_gap());
        // Song 1 from its first entry
        drive_frame(ACT_PLAY);
        idle_frames(12);
        ff_switch <= 1'b0;
        idle_frames(8 + random_gap());
        // Skip during play so song 2 starts at entry 0
        drive_frame(ACT_NEXT);
        idle_frames(3);
        drive_frame(ACT_PLAY);
        idle_frames(16);
        // Only note 32 at the end of song 3 sets the phase MSB within its beats
        play_to_end();
        idle_frames(2);
        drive_frame(ACT_PLAY);
        play_to_end();
        idle_frames(2);
        report_and_finish();
    end

endmodule

// ==== compile.f ====
hdl/music_pkg.sv
hdl/mcu.sv
hdl/song_reader.sv
hdl/note_player.sv
hdl/beat_generator.sv
hdl/codec_conditioner.sv
hdl/music_player.sv
bench/music_player_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the music player testbench with Verilator, run it, check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module music_player_tb -o music_player_sim
./obj_dir/music_player_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
